// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert -f build.f --top-module core_tb -Mdir obj_dir
	@out="$$(./obj_dir/Vcore_tb)"; echo "$$out"; \
	echo "$$out" | grep -q "^Testbench passed$$"

clean:
	rm -rf obj_dir

// ==== build.f ====
common/core_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/reg_file.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/core_top.sv
testbench/core_tb.sv

// ==== common/core_pkg.sv ====
package core_pkg;

    // ******************************
    // widths and sizes
    // ******************************
    localparam int XLEN       = 64;
    localparam int ILEN       = 32;
    localparam int REG_COUNT  = 32;
    localparam int DMEM_WORDS = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [ILEN-1:0] inst_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [2:0]      alu_sel_t;
    typedef logic [1:0]      mem_size_t;

    localparam xlen_t RESET_PC = '0;
    // addi x0, x0, 0
    localparam inst_t NOP_INST = 32'h0000_0013;

    // major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // alu select codes
    localparam alu_sel_t ALU_ADD = 3'd0;
    localparam alu_sel_t ALU_SUB = 3'd1;
    localparam alu_sel_t ALU_AND = 3'd2;
    localparam alu_sel_t ALU_OR  = 3'd3;
    localparam alu_sel_t ALU_XOR = 3'd4;
    localparam alu_sel_t ALU_SLL = 3'd5;
    localparam alu_sel_t ALU_SRL = 3'd6;
    localparam alu_sel_t ALU_SLT = 3'd7;

    // access size, same as funct3[1:0] of lw/sw and ld/sd
    localparam mem_size_t MEM_WORD   = 2'b10;
    localparam mem_size_t MEM_DOUBLE = 2'b11;

    // ******************************
    // pipeline registers
    // ******************************
    typedef struct packed {
        logic  valid;
        xlen_t pc;
        inst_t inst;
    } if_id_t;

    typedef struct packed {
        logic      valid;
        xlen_t     pc;
        inst_t     inst;
        xlen_t     op1;
        xlen_t     op2;
        alu_sel_t  alu_sel;
        logic      rd_we;
        reg_idx_t  rd_idx;
        logic      is_load;
        logic      is_store;
        mem_size_t size;
        xlen_t     store_data;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        xlen_t     pc;
        inst_t     inst;
        xlen_t     result;
        logic      rd_we;
        reg_idx_t  rd_idx;
        logic      is_load;
        logic      is_store;
        mem_size_t size;
        xlen_t     store_data;
    } ex_mem_t;

    // retired instruction, also the register file write port
    typedef struct packed {
        logic     valid;
        xlen_t    pc;
        inst_t    inst;
        logic     rd_we;
        reg_idx_t rd_idx;
        xlen_t    rd_data;
    } commit_t;

endpackage

// ==== logic/core_top.sv ====
`timescale 1ns/1ps

module core_top (
    input  logic               clk_i,
    input  logic               rst_i,
    output core_pkg::xlen_t    imem_addr_o,
    input  core_pkg::inst_t    imem_data_i,
    output core_pkg::commit_t  commit_o
);

    core_pkg::if_id_t   if_id;
    core_pkg::id_ex_t   id_ex;
    core_pkg::ex_mem_t  ex_mem;
    core_pkg::reg_idx_t rs1_idx;
    core_pkg::reg_idx_t rs2_idx;
    core_pkg::xlen_t    rs1_data;
    core_pkg::xlen_t    rs2_data;
    // only loads stall the front of the pipe
    logic               stall;

    fetch_stage fetch_stage_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .stall_i     (stall),
        .imem_addr_o (imem_addr_o),
        .imem_data_i (imem_data_i),
        .if_id_o     (if_id)
    );

    decode_stage decode_stage_i (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .stall_i    (stall),
        .if_id_i    (if_id),
        .rs1_idx_o  (rs1_idx),
        .rs2_idx_o  (rs2_idx),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .id_ex_o    (id_ex)
    );

    reg_file reg_file_i (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rs1_idx_i  (rs1_idx),
        .rs2_idx_i  (rs2_idx),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb_i       (commit_o)
    );

    execute_stage execute_stage_i (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .stall_i  (stall),
        .id_ex_i  (id_ex),
        .ex_mem_o (ex_mem)
    );

    memory_stage memory_stage_i (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .ex_mem_i (ex_mem),
        .stall_o  (stall),
        .commit_o (commit_o)
    );

endmodule

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                stall_i,
    input  core_pkg::if_id_t    if_id_i,
    output core_pkg::reg_idx_t  rs1_idx_o,
    output core_pkg::reg_idx_t  rs2_idx_o,
    input  core_pkg::xlen_t     rs1_data_i,
    input  core_pkg::xlen_t     rs2_data_i,
    output core_pkg::id_ex_t    id_ex_o
);

    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    core_pkg::xlen_t    imm_i;
    core_pkg::xlen_t    imm_s;
    core_pkg::xlen_t    imm_u;
    core_pkg::id_ex_t   dec;
    logic               legal;

    // instruction fields
    assign opcode    = if_id_i.inst[6:0];
    assign funct3    = if_id_i.inst[14:12];
    assign funct7    = if_id_i.inst[31:25];
    assign rs1_idx_o = if_id_i.inst[19:15];
    assign rs2_idx_o = if_id_i.inst[24:20];

    // immediates sign extended from bit 31
    assign imm_i = {{52{if_id_i.inst[31]}}, if_id_i.inst[31:20]};
    assign imm_s = {{52{if_id_i.inst[31]}}, if_id_i.inst[31:25], if_id_i.inst[11:7]};
    assign imm_u = {{32{if_id_i.inst[31]}}, if_id_i.inst[31:12], 12'b0};

    always_comb begin
        dec            = '0;
        dec.valid      = if_id_i.valid;
        dec.pc         = if_id_i.pc;
        dec.inst       = if_id_i.inst;
        dec.op1        = rs1_data_i;
        dec.op2        = imm_i;
        dec.alu_sel    = core_pkg::ALU_ADD;
        dec.rd_idx     = if_id_i.inst[11:7];
        dec.size       = funct3[1:0];
        dec.store_data = rs2_data_i;
        legal          = 1'b0;
        case (funct3)
            3'b001:  dec.alu_sel = core_pkg::ALU_SLL;
            3'b010:  dec.alu_sel = core_pkg::ALU_SLT;
            3'b100:  dec.alu_sel = core_pkg::ALU_XOR;
            3'b101:  dec.alu_sel = core_pkg::ALU_SRL;
            3'b110:  dec.alu_sel = core_pkg::ALU_OR;
            3'b111:  dec.alu_sel = core_pkg::ALU_AND;
            default: dec.alu_sel = core_pkg::ALU_ADD;
        endcase
        case (opcode)
            core_pkg::OPC_OP: begin
                dec.op2   = rs2_data_i;
                dec.rd_we = 1'b1;
                legal     = (funct7 == 7'h00) || (funct7 == 7'h20 && funct3 == 3'b000);
                if (funct7[5]) begin
                    dec.alu_sel = core_pkg::ALU_SUB;
                end
            end
            core_pkg::OPC_OP_IMM: begin
                // addi, xori, ori, andi only
                dec.rd_we = 1'b1;
                legal     = (funct3 == 3'b000) || funct3[2];
                legal     = legal && (funct3 != 3'b101);
            end
            core_pkg::OPC_LUI: begin
                dec.op1     = '0;
                dec.op2     = imm_u;
                dec.alu_sel = core_pkg::ALU_ADD;
                dec.rd_we   = 1'b1;
                legal       = 1'b1;
            end
            core_pkg::OPC_LOAD, core_pkg::OPC_STORE: begin
                dec.alu_sel  = core_pkg::ALU_ADD;
                dec.is_load  = (opcode == core_pkg::OPC_LOAD);
                dec.is_store = (opcode == core_pkg::OPC_STORE);
                dec.rd_we    = dec.is_load;
                dec.op2      = dec.is_store ? imm_s : imm_i;
                legal        = (funct3 == 3'b010) || (funct3 == 3'b011);
            end
            default: legal = 1'b0;
        endcase
        // unknown instruction still retires but changes nothing
        if (!legal) begin
            dec.rd_we    = 1'b0;
            dec.is_load  = 1'b0;
            dec.is_store = 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            id_ex_o.valid <= 1'b0;
        end else if (!stall_i) begin
            id_ex_o <= dec;
        end
    end

endmodule

// ==== logic/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               stall_i,
    input  core_pkg::id_ex_t   id_ex_i,
    output core_pkg::ex_mem_t  ex_mem_o
);

    core_pkg::xlen_t alu_res;
    logic [5:0]      shamt;

    assign shamt = id_ex_i.op2[5:0];

    // ******************************
    // alu
    // ******************************
    always_comb begin
        case (id_ex_i.alu_sel)
            core_pkg::ALU_ADD: alu_res = id_ex_i.op1 + id_ex_i.op2;
            core_pkg::ALU_SUB: alu_res = id_ex_i.op1 - id_ex_i.op2;
            core_pkg::ALU_AND: alu_res = id_ex_i.op1 & id_ex_i.op2;
            core_pkg::ALU_OR:  alu_res = id_ex_i.op1 | id_ex_i.op2;
            core_pkg::ALU_XOR: alu_res = id_ex_i.op1 ^ id_ex_i.op2;
            core_pkg::ALU_SLL: alu_res = id_ex_i.op1 << shamt;
            core_pkg::ALU_SRL: alu_res = id_ex_i.op1 >> shamt;
            core_pkg::ALU_SLT: begin
                alu_res = {63'b0, $signed(id_ex_i.op1) < $signed(id_ex_i.op2)};
            end
            default:           alu_res = '0;
        endcase
    end

    // ex/mem register, load and store address is the add result
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ex_mem_o.valid <= 1'b0;
        end else if (!stall_i) begin
            ex_mem_o.valid      <= id_ex_i.valid;
            ex_mem_o.pc         <= id_ex_i.pc;
            ex_mem_o.inst       <= id_ex_i.inst;
            ex_mem_o.result     <= alu_res;
            ex_mem_o.rd_we      <= id_ex_i.rd_we;
            ex_mem_o.rd_idx     <= id_ex_i.rd_idx;
            ex_mem_o.is_load    <= id_ex_i.is_load;
            ex_mem_o.is_store   <= id_ex_i.is_store;
            ex_mem_o.size       <= id_ex_i.size;
            ex_mem_o.store_data <= id_ex_i.store_data;
        end
    end

endmodule

// ==== logic/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              stall_i,
    output core_pkg::xlen_t   imem_addr_o,
    input  core_pkg::inst_t   imem_data_i,
    output core_pkg::if_id_t  if_id_o
);

    core_pkg::xlen_t pc_q;

    // instruction memory answers in the same cycle
    assign imem_addr_o = pc_q;

    // ******************************
    // pc and if/id register
    // ******************************
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q          <= core_pkg::RESET_PC;
            if_id_o.valid <= 1'b0;
        end else if (!stall_i) begin
            // sequential fetch only, no jumps
            pc_q          <= pc_q + core_pkg::XLEN'(4);
            if_id_o.valid <= 1'b1;
        end
    end

    // payload holds while the load finishes
    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            if_id_o.pc   <= pc_q;
            if_id_o.inst <= imem_data_i;
        end
    end

endmodule

// ==== logic/memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage (
    input  logic               clk_i,
    input  logic               rst_i,
    input  core_pkg::ex_mem_t  ex_mem_i,
    output logic               stall_o,
    output core_pkg::commit_t  commit_o
);

    localparam int IDX_W = $clog2(core_pkg::DMEM_WORDS);

    core_pkg::xlen_t  dmem [core_pkg::DMEM_WORDS];
    core_pkg::xlen_t  rdata_q;
    logic             load_pending_q;
    logic [IDX_W-1:0] word_idx;
    logic             is_word;
    logic [7:0]       byte_strb;
    core_pkg::xlen_t  wdata;
    logic [31:0]      half;
    core_pkg::xlen_t  load_data;

    assign word_idx = ex_mem_i.result[IDX_W+2:3];
    assign is_word  = (ex_mem_i.size == core_pkg::MEM_WORD);

    // first cycle of a load waits for the ram
    assign stall_o = ex_mem_i.valid && ex_mem_i.is_load && !load_pending_q;

    // sw lands in the half picked by addr[2]
    always_comb begin
        if (is_word) begin
            byte_strb = ex_mem_i.result[2] ? 8'hf0 : 8'h0f;
            wdata     = {2{ex_mem_i.store_data[31:0]}};
        end else begin
            byte_strb = 8'hff;
            wdata     = ex_mem_i.store_data;
        end
    end

    // ******************************
    // data ram with sync read
    // ******************************
    always_ff @(posedge clk_i) begin
        if (ex_mem_i.valid && ex_mem_i.is_store) begin
            for (int b = 0; b < 8; b++) begin
                if (byte_strb[b]) begin
                    dmem[word_idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
        rdata_q <= dmem[word_idx];
    end

    // lw sign extends
    assign half      = ex_mem_i.result[2] ? rdata_q[63:32] : rdata_q[31:0];
    assign load_data = is_word ? {{32{half[31]}}, half} : rdata_q;

    // ******************************
    // writeback register
    // ******************************
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            load_pending_q <= 1'b0;
            commit_o.valid <= 1'b0;
            commit_o.rd_we <= 1'b0;
        end else begin
            load_pending_q <= stall_o;
            if (stall_o) begin
                // bubble while the ram reads
                commit_o.valid <= 1'b0;
                commit_o.rd_we <= 1'b0;
            end else begin
                commit_o.valid   <= ex_mem_i.valid;
                commit_o.pc      <= ex_mem_i.pc;
                commit_o.inst    <= ex_mem_i.inst;
                commit_o.rd_we   <= ex_mem_i.valid && ex_mem_i.rd_we;
                commit_o.rd_idx  <= ex_mem_i.rd_idx;
                commit_o.rd_data <= ex_mem_i.is_load ? load_data : ex_mem_i.result;
            end
        end
    end

    // the load waits in place for its data
    a_load_held: assert property (@(posedge clk_i) disable iff (rst_i)
        stall_o |=> $stable(ex_mem_i));

    a_aligned_access: assert property (@(posedge clk_i) disable iff (rst_i)
        ex_mem_i.valid && (ex_mem_i.is_load || ex_mem_i.is_store) |->
        (is_word ? ex_mem_i.result[1:0] == 2'b00 : ex_mem_i.result[2:0] == 3'b000));

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                clk_i,
    input  logic                rst_i,
    input  core_pkg::reg_idx_t  rs1_idx_i,
    input  core_pkg::reg_idx_t  rs2_idx_i,
    output core_pkg::xlen_t     rs1_data_o,
    output core_pkg::xlen_t     rs2_data_o,
    input  core_pkg::commit_t   wb_i
);

    // x0 has no storage
    core_pkg::xlen_t regs [1:core_pkg::REG_COUNT-1];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 1; i < core_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.valid && wb_i.rd_we && wb_i.rd_idx != '0) begin
            regs[wb_i.rd_idx] <= wb_i.rd_data;
        end
    end

    // no bypass from the write port
    assign rs1_data_o = (rs1_idx_i == '0) ? '0 : regs[rs1_idx_i];
    assign rs2_data_o = (rs2_idx_i == '0) ? '0 : regs[rs2_idx_i];

    a_write_needs_commit: assert property (@(posedge clk_i) disable iff (rst_i)
        wb_i.rd_we |-> wb_i.valid);

endmodule

// ==== testbench/core_tb.sv ====
`timescale 1ns/1ps

module core_tb;

    localparam int PAD         = 3;
    localparam int COMMIT_WAIT = 8;
    // padded program lengths of the five tests
    localparam int PROG_INSTS  = 16 + 52 + 36 + 60 + 42;
    localparam int MAX_CYCLES  = 40 * PROG_INSTS;

    logic                clk;
    logic                rst;
    core_pkg::xlen_t     imem_addr;
    core_pkg::inst_t     imem_data;
    core_pkg::commit_t   commit;

    core_pkg::inst_t     imem [256];
    core_pkg::xlen_t     ref_regs [32];
    core_pkg::xlen_t     ref_mem [32];
    core_pkg::inst_t     prog [$];
    logic                exp_we [$];
    core_pkg::reg_idx_t  exp_idx [$];
    core_pkg::xlen_t     exp_data [$];
    logic [31:0]         lfsr_q = 32'h5b8f;
    string               test_name;
    int                  cycle_count;
    int                  checks;
    int                  errors;

    core_top core_top_i (
        .clk_i       (clk),
        .rst_i       (rst),
        .imem_addr_o (imem_addr),
        .imem_data_i (imem_data),
        .commit_o    (commit)
    );

    // instruction memory answers combinationally
    assign imem_data = imem[imem_addr[9:2]];

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    // ******************************
    // helpers
    // ******************************
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (4) next_cycle();
        rst = 1'b0;
    endtask

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            // taps 32, 22, 2, 1
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic check_xlen(input string what, input core_pkg::xlen_t exp,
                              input core_pkg::xlen_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_idx(input core_pkg::reg_idx_t exp, input core_pkg::reg_idx_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR %s rd_idx: expected %0d, actual %0d", test_name, exp, act);
        end
    endtask

    task automatic check_commit_pc(input core_pkg::xlen_t exp, input core_pkg::xlen_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR %s commit pc: expected %h, actual %h", test_name, exp, act);
        end
    endtask

    task automatic check_inst(input core_pkg::inst_t exp, input core_pkg::inst_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR %s commit inst: expected %h, actual %h", test_name, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR %s %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    // ******************************
    // encoders and reference model
    // ******************************
    function automatic core_pkg::inst_t enc_r(input logic [6:0] f7, input core_pkg::reg_idx_t rs2,
        input core_pkg::reg_idx_t rs1, input logic [2:0] f3, input core_pkg::reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, core_pkg::OPC_OP};
    endfunction

    function automatic core_pkg::inst_t enc_i(input logic [11:0] imm, input core_pkg::reg_idx_t rs1,
        input logic [2:0] f3, input core_pkg::reg_idx_t rd, input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic core_pkg::inst_t enc_s(input logic [11:0] imm, input core_pkg::reg_idx_t rs2,
        input logic [2:0] f3);
        return {imm[11:5], rs2, 5'd0, f3, imm[4:0], core_pkg::OPC_STORE};
    endfunction

    function automatic core_pkg::xlen_t ref_alu(input logic [2:0] f3, input logic alt,
        input core_pkg::xlen_t a, input core_pkg::xlen_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[5:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            3'b100:  return a ^ b;
            3'b101:  return a >> b[5:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic start_program(input string name);
        test_name = name;
        prog.delete();
        exp_we.delete();
        exp_idx.delete();
        exp_data.delete();
        // the register file clears on every reset
        for (int r = 0; r < 32; r++) begin
            ref_regs[r] = '0;
        end
    endtask

    // one instruction and its expected commit followed by nops
    task automatic emit(input core_pkg::inst_t inst, input logic we, input core_pkg::reg_idx_t rd,
        input core_pkg::xlen_t data, input int pad);
        prog.push_back(inst);
        exp_we.push_back(we);
        exp_idx.push_back(rd);
        exp_data.push_back(data);
        for (int k = 0; k < pad; k++) begin
            prog.push_back(core_pkg::NOP_INST);
            exp_we.push_back(1'b1);
            exp_idx.push_back(5'd0);
            exp_data.push_back('0);
        end
        if (rd != 5'd0 && we) begin
            ref_regs[rd] = data;
        end
    endtask

    task automatic reg_op(input logic [2:0] f3, input logic alt, input core_pkg::reg_idx_t rd,
        input core_pkg::reg_idx_t rs1, input core_pkg::reg_idx_t rs2, input int pad);
        core_pkg::xlen_t res;
        res = ref_alu(f3, alt, ref_regs[rs1], ref_regs[rs2]);
        emit(enc_r({1'b0, alt, 5'b0}, rs2, rs1, f3, rd), 1'b1, rd, res, pad);
    endtask

    task automatic imm_op(input logic [2:0] f3, input core_pkg::reg_idx_t rd,
        input core_pkg::reg_idx_t rs1, input logic [11:0] imm, input int pad);
        core_pkg::xlen_t res;
        res = ref_alu(f3, 1'b0, ref_regs[rs1], {{52{imm[11]}}, imm});
        emit(enc_i(imm, rs1, f3, rd, core_pkg::OPC_OP_IMM), 1'b1, rd, res, pad);
    endtask

    task automatic lui_inst(input core_pkg::reg_idx_t rd, input logic [19:0] imm, input int pad);
        emit({imm, rd, core_pkg::OPC_LUI}, 1'b1, rd, {{32{imm[19]}}, imm, 12'b0}, pad);
    endtask

    // rounded upper part by lui and low part by addi
    task automatic load_const(input core_pkg::reg_idx_t rd, input logic [31:0] v);
        logic [31:0] t;
        t = v + 32'h800;
        lui_inst(rd, t[31:12], PAD);
        imm_op(3'b000, rd, rd, v[11:0], PAD);
    endtask

    task automatic load_inst(input logic dbl, input core_pkg::reg_idx_t rd, input logic [11:0] off,
        input int pad);
        core_pkg::xlen_t addr;
        core_pkg::xlen_t word;
        logic [31:0]     half;
        addr = {{52{off[11]}}, off};
        word = ref_mem[addr[7:3]];
        half = addr[2] ? word[63:32] : word[31:0];
        emit(enc_i(off, 5'd0, {2'b01, dbl}, rd, core_pkg::OPC_LOAD), 1'b1, rd,
             dbl ? word : {{32{half[31]}}, half}, pad);
    endtask

    task automatic store_inst(input logic dbl, input core_pkg::reg_idx_t rs2, input logic [11:0] off,
        input int pad);
        core_pkg::xlen_t addr;
        addr = {{52{off[11]}}, off};
        if (dbl) begin
            ref_mem[addr[7:3]] = ref_regs[rs2];
        end else if (addr[2]) begin
            ref_mem[addr[7:3]][63:32] = ref_regs[rs2][31:0];
        end else begin
            ref_mem[addr[7:3]][31:0] = ref_regs[rs2][31:0];
        end
        emit(enc_s(off, rs2, {2'b01, dbl}), 1'b0, 5'd0, '0, pad);
    endtask

    task automatic load_program();
        for (int a = 0; a < 256; a++) begin
            imem[a] = core_pkg::NOP_INST;
        end
        for (int a = 0; a < prog.size(); a++) begin
            imem[a] = prog[a];
        end
        apply_reset();
    endtask

    task automatic collect_commits();
        int waited;
        for (int i = 0; i < prog.size(); i++) begin
            waited = 0;
            while (!commit.valid && waited < COMMIT_WAIT) begin
                next_cycle();
                waited++;
            end
            if (!commit.valid) begin
                errors++;
                $display("%s: the instruction at pc %0h never committed", test_name, 4 * i);
                return;
            end
            check_commit_pc(core_pkg::xlen_t'(4 * i), commit.pc);
            check_inst(prog[i], commit.inst);
            check_flag("rd_we", exp_we[i], commit.rd_we);
            if (exp_we[i]) begin
                check_idx(exp_idx[i], commit.rd_idx);
                check_xlen("rd_data", exp_data[i], commit.rd_data);
            end
            next_cycle();
        end
    endtask

    // ******************************
    // tests
    // ******************************
    task automatic test_reset();
        start_program("reset");
        for (int k = 0; k < 16; k++) begin
            emit(core_pkg::NOP_INST, 1'b1, 5'd0, '0, 0);
        end
        load_program();
        check_xlen("imem_addr", core_pkg::RESET_PC, imem_addr);
        check_flag("commit valid", 1'b0, commit.valid);
        for (int k = 1; k <= 8; k++) begin
            next_cycle();
            check_xlen("imem_addr", core_pkg::RESET_PC + core_pkg::xlen_t'(4 * k), imem_addr);
            // first fetch retires after the fourth edge
            check_flag("commit valid", k >= 4, commit.valid);
        end
    endtask

    task automatic test_reg_ops();
        start_program("reg_ops");
        load_const(5'd1, rand_bits(32));
        load_const(5'd2, rand_bits(32));
        reg_op(3'b000, 1'b0, 5'd3, 5'd1, 5'd2, PAD);
        reg_op(3'b000, 1'b1, 5'd4, 5'd1, 5'd2, PAD);
        reg_op(3'b111, 1'b0, 5'd5, 5'd1, 5'd2, PAD);
        reg_op(3'b110, 1'b0, 5'd6, 5'd1, 5'd2, PAD);
        reg_op(3'b100, 1'b0, 5'd7, 5'd1, 5'd2, PAD);
        reg_op(3'b001, 1'b0, 5'd8, 5'd1, 5'd2, PAD);
        reg_op(3'b101, 1'b0, 5'd9, 5'd1, 5'd2, PAD);
        reg_op(3'b010, 1'b0, 5'd10, 5'd1, 5'd2, PAD);
        reg_op(3'b010, 1'b0, 5'd11, 5'd2, 5'd1, PAD);
        load_program();
        collect_commits();
    endtask

    task automatic test_imm_ops();
        start_program("imm_ops");
        lui_inst(5'd1, 20'hfedcb, PAD);
        lui_inst(5'd2, 20'h12345, PAD);
        imm_op(3'b000, 5'd3, 5'd2, 12'hffb, PAD);
        imm_op(3'b111, 5'd4, 5'd1, 12'hf0f, PAD);
        imm_op(3'b110, 5'd5, 5'd2, 12'h800, PAD);
        imm_op(3'b100, 5'd6, 5'd2, 12'hfff, PAD);
        // x0 takes the write and still reads zero
        imm_op(3'b000, 5'd0, 5'd1, 12'h07b, PAD);
        reg_op(3'b000, 1'b0, 5'd7, 5'd0, 5'd2, PAD);
        reg_op(3'b110, 1'b0, 5'd8, 5'd0, 5'd0, PAD);
        load_program();
        collect_commits();
    endtask

    task automatic test_load_store();
        start_program("load_store");
        load_const(5'd1, rand_bits(32));
        load_const(5'd2, rand_bits(32));
        imm_op(3'b000, 5'd4, 5'd0, 12'd32, PAD);
        reg_op(3'b001, 1'b0, 5'd3, 5'd1, 5'd4, PAD);
        reg_op(3'b100, 1'b0, 5'd3, 5'd3, 5'd2, PAD);
        store_inst(1'b1, 5'd3, 12'h040, PAD);
        load_inst(1'b1, 5'd5, 12'h040, PAD);
        store_inst(1'b0, 5'd2, 12'h040, PAD);
        load_inst(1'b0, 5'd6, 12'h040, PAD);
        load_inst(1'b1, 5'd7, 12'h040, PAD);
        store_inst(1'b0, 5'd1, 12'h044, PAD);
        load_inst(1'b0, 5'd8, 12'h044, PAD);
        load_inst(1'b1, 5'd9, 12'h040, PAD);
        load_program();
        collect_commits();
    endtask

    task automatic test_mixed_order();
        start_program("mixed_order");
        load_const(5'd1, rand_bits(32));
        load_const(5'd2, rand_bits(32));
        store_inst(1'b1, 5'd1, 12'h010, PAD);
        store_inst(1'b0, 5'd2, 12'h01c, PAD);
        // two back to back loads that each stall once
        load_inst(1'b1, 5'd3, 12'h010, 0);
        load_inst(1'b0, 5'd4, 12'h01c, 0);
        reg_op(3'b000, 1'b0, 5'd5, 5'd1, 5'd2, PAD);
        load_inst(1'b1, 5'd6, 12'h010, PAD);
        reg_op(3'b100, 1'b0, 5'd7, 5'd3, 5'd4, PAD);
        reg_op(3'b000, 1'b1, 5'd8, 5'd6, 5'd5, PAD);
        load_program();
        collect_commits();
    endtask

    initial begin
        rst = 1'b1;
        for (int a = 0; a < 256; a++) begin
            imem[a] = core_pkg::NOP_INST;
        end
        test_reset();
        test_reg_ops();
        test_imm_ops();
        test_load_store();
        test_mixed_order();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
